/* source/dcachePkg.sv */
// Data cache shared definitions
`default_nettype none

package dcachePkg;

	// byte address and word geometry
	localparam int addrWidth = 32;
	localparam int wordBits = 32;
	localparam int wordBytes = 4;

	// block geometry
	localparam int blockWords = 4;
	localparam int blockBytes = 16;
	localparam int offsetWidth = 4;
	localparam int blockBits = 128;

	// one cache block, seen as words or as bytes
	// words feed the read mux and memory transfers,
	// bytes feed the byte-enabled merge on a write hit
	typedef union packed {
		logic [blockWords-1:0][wordBits-1:0] words;
		logic [blockBytes-1:0][7:0] bytes;
	} dcacheBlock;

	// miss handling states
	typedef enum logic [2:0] {
		idle = 3'd0,
		miss = 3'd1,
		writeBack = 3'd2,
		memRead = 3'd3,
		memFill = 3'd4
	} controllerState;

endpackage

`default_nettype wire

/* source/dcacheController.sv */
// Data cache miss controller
`default_nettype none

module dcacheController #(
	parameter int numSets = 16,
	localparam int indexWidth = $clog2(numSets),
	localparam int tagWidth = dcachePkg::addrWidth - dcachePkg::offsetWidth - indexWidth
) (
	input wire logic clock,
	input wire logic reset,

	// pipeline request
	input wire logic ren,
	input wire logic wen,
	input wire logic [dcachePkg::addrWidth-1:0] addr,
	input wire logic [dcachePkg::wordBytes-1:0] byteSelect,
	input wire logic [dcachePkg::wordBits-1:0] din,

	// from the tag and data stores
	input wire logic hit,
	input wire logic victimDirty,
	input wire logic [tagWidth-1:0] victimTag,
	input wire dcachePkg::dcacheBlock cacheBlock,

	// from memory
	input wire logic memReadReady,
	input wire logic memWriteDone,
	input wire dcachePkg::dcacheBlock memDout,

	// to the pipeline
	output logic stall,
	output logic [dcachePkg::wordBits-1:0] dout,

	// to the tag and data stores
	output logic [indexWidth-1:0] setIndex,
	output logic [tagWidth-1:0] reqTag,
	output logic wordWrite,
	output logic [dcachePkg::blockBytes-1:0] byteEnable,
	output dcachePkg::dcacheBlock writeBlock,
	output logic fillWrite,

	// to memory
	output logic memRen,
	output logic memWen,
	output logic [dcachePkg::addrWidth-dcachePkg::offsetWidth-1:0] memBlockAddr,
	output dcachePkg::dcacheBlock memDin
);

	import dcachePkg::*;

	localparam int byteSelWidth = $clog2(wordBytes);
	localparam int wordSelWidth = $clog2(blockWords);

	controllerState state;
	controllerState nextState;

	logic validReq;
	logic [wordSelWidth-1:0] wordIndex;
	dcacheBlock laneBlock;
	dcacheBlock fillBuffer;

	// exactly one of ren and wen makes a request
	assign validReq = ren ^ wen;

	// address split into tag, set and word within the block
	assign reqTag = addr[addrWidth-1 -: tagWidth];
	assign setIndex = addr[offsetWidth +: indexWidth];
	assign wordIndex = addr[byteSelWidth +: wordSelWidth];

	// read hit path
	assign dout = cacheBlock.words[wordIndex];

	// din copied into every word lane, enables pick the addressed one
	always_comb begin
		for (int i = 0; i < blockBytes; i++) begin
			laneBlock.bytes[i] = din[(i % wordBytes) * 8 +: 8];
			byteEnable[i] = (i / wordBytes == wordIndex) && byteSelect[i % wordBytes];
		end
	end

	// write hit only from idle, a retried write lands here too
	assign wordWrite = (state == idle) && wen && !ren && hit;

	// full block fill from the buffer, otherwise the merged word
	assign fillWrite = (state == memFill);
	assign writeBlock = fillWrite ? fillBuffer : laneBlock;

	// victim block always comes straight from the data store
	assign memDin = cacheBlock;

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			state <= idle;
		end else begin
			state <= nextState;
		end
	end

	// holds the fetched block until memFill
	always_ff @(posedge clock) begin
		if (state == memRead && memReadReady) begin
			fillBuffer <= memDout;
		end
	end

	always_comb begin
		nextState = state;
		case (state)
			idle: begin
				if (validReq && !hit) begin
					nextState = miss;
				end
			end
			miss: begin
				// dirty victim goes out before the fetch
				nextState = victimDirty ? writeBack : memRead;
			end
			writeBack: begin
				if (memWriteDone) begin
					nextState = memRead;
				end
			end
			memRead: begin
				if (memReadReady) begin
					nextState = memFill;
				end
			end
			memFill: begin
				nextState = idle;
			end
			default: begin
				nextState = idle;
			end
		endcase
	end

	always_comb begin
		stall = 1'b1;
		memRen = 1'b0;
		memWen = 1'b0;
		memBlockAddr = {reqTag, setIndex};
		case (state)
			idle: begin
				// raised in the request cycle of a miss
				stall = validReq && !hit;
			end
			writeBack: begin
				memWen = 1'b1;
				memBlockAddr = {victimTag, setIndex};
			end
			memRead: begin
				memRen = 1'b1;
			end
			default: begin
				stall = 1'b1;
			end
		endcase
	end

endmodule

`default_nettype wire

/* source/dcacheTagStore.sv */
// Data cache tag store
`default_nettype none

module dcacheTagStore #(
	parameter int numSets = 16,
	localparam int indexWidth = $clog2(numSets),
	localparam int tagWidth = dcachePkg::addrWidth - dcachePkg::offsetWidth - indexWidth
) (
	input wire logic clock,
	input wire logic reset,

	// lookup and update controls
	input wire logic [indexWidth-1:0] setIndex,
	input wire logic [tagWidth-1:0] reqTag,
	input wire logic wordWrite,
	input wire logic fillWrite,

	// lookup results
	output logic hit,
	output logic victimDirty,
	output logic [tagWidth-1:0] victimTag
);

	logic [tagWidth-1:0] tags [numSets];
	logic [numSets-1:0] valid;
	logic [numSets-1:0] dirty;

	// combinational lookup of the indexed line
	assign victimTag = tags[setIndex];
	assign hit = valid[setIndex] && (tags[setIndex] == reqTag);

	// an invalid line never needs a writeback
	assign victimDirty = valid[setIndex] && dirty[setIndex];

	// status bits
	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			valid <= '0;
			dirty <= '0;
		end else if (fillWrite) begin
			// freshly fetched line matches memory
			valid[setIndex] <= 1'b1;
			dirty[setIndex] <= 1'b0;
		end else if (wordWrite) begin
			dirty[setIndex] <= 1'b1;
		end
	end

	// tag is installed with the fill
	always_ff @(posedge clock) begin
		if (fillWrite) begin
			tags[setIndex] <= reqTag;
		end
	end

endmodule

`default_nettype wire

/* source/dcacheDataStore.sv */
// Data cache block store
`default_nettype none

module dcacheDataStore #(
	parameter int numSets = 16,
	localparam int indexWidth = $clog2(numSets)
) (
	input wire logic clock,

	// write controls
	input wire logic [indexWidth-1:0] setIndex,
	input wire logic wordWrite,
	input wire logic fillWrite,
	input wire logic [dcachePkg::blockBytes-1:0] byteEnable,
	input wire dcachePkg::dcacheBlock writeBlock,

	// indexed block
	output dcachePkg::dcacheBlock readBlock
);

	import dcachePkg::*;

	dcacheBlock blocks [numSets];

	// read is combinational
	assign readBlock = blocks[setIndex];

	always_ff @(posedge clock) begin
		if (fillWrite) begin
			// whole block replaced on a fill
			blocks[setIndex] <= writeBlock;
		end else if (wordWrite) begin
			// only the enabled bytes change
			for (int i = 0; i < blockBytes; i++) begin
				if (byteEnable[i]) begin
					blocks[setIndex].bytes[i] <= writeBlock.bytes[i];
				end
			end
		end
	end

endmodule

`default_nettype wire

/* source/dcacheTop.sv */
// Direct-mapped data cache
`default_nettype none

module dcacheTop #(
	parameter int numSets = 16,
	localparam int indexWidth = $clog2(numSets),
	localparam int tagWidth = dcachePkg::addrWidth - dcachePkg::offsetWidth - indexWidth
) (
	input wire logic clock,
	input wire logic reset,

	// pipeline port
	input wire logic ren,
	input wire logic wen,
	input wire logic [dcachePkg::addrWidth-1:0] addr,
	input wire logic [dcachePkg::wordBytes-1:0] byteSelect,
	input wire logic [dcachePkg::wordBits-1:0] din,
	output logic stall,
	output logic [dcachePkg::wordBits-1:0] dout,

	// memory port
	output logic memRen,
	output logic memWen,
	output logic [dcachePkg::addrWidth-dcachePkg::offsetWidth-1:0] memBlockAddr,
	output dcachePkg::dcacheBlock memDin,
	input wire logic memReadReady,
	input wire logic memWriteDone,
	input wire dcachePkg::dcacheBlock memDout
);

	import dcachePkg::*;

	// controller to stores
	logic [indexWidth-1:0] setIndex;
	logic [tagWidth-1:0] reqTag;
	logic wordWrite;
	logic fillWrite;
	logic [blockBytes-1:0] byteEnable;
	dcacheBlock writeBlock;

	// stores back to controller
	logic hit;
	logic victimDirty;
	logic [tagWidth-1:0] victimTag;
	dcacheBlock cacheBlock;

	dcacheController #(
		.numSets(numSets)
	) controller (
		.clock(clock),
		.reset(reset),
		.ren(ren),
		.wen(wen),
		.addr(addr),
		.byteSelect(byteSelect),
		.din(din),
		.hit(hit),
		.victimDirty(victimDirty),
		.victimTag(victimTag),
		.cacheBlock(cacheBlock),
		.memReadReady(memReadReady),
		.memWriteDone(memWriteDone),
		.memDout(memDout),
		.stall(stall),
		.dout(dout),
		.setIndex(setIndex),
		.reqTag(reqTag),
		.wordWrite(wordWrite),
		.byteEnable(byteEnable),
		.writeBlock(writeBlock),
		.fillWrite(fillWrite),
		.memRen(memRen),
		.memWen(memWen),
		.memBlockAddr(memBlockAddr),
		.memDin(memDin)
	);

	dcacheTagStore #(
		.numSets(numSets)
	) tagStore (
		.clock(clock),
		.reset(reset),
		.setIndex(setIndex),
		.reqTag(reqTag),
		.wordWrite(wordWrite),
		.fillWrite(fillWrite),
		.hit(hit),
		.victimDirty(victimDirty),
		.victimTag(victimTag)
	);

	dcacheDataStore #(
		.numSets(numSets)
	) dataStore (
		.clock(clock),
		.setIndex(setIndex),
		.wordWrite(wordWrite),
		.fillWrite(fillWrite),
		.byteEnable(byteEnable),
		.writeBlock(writeBlock),
		.readBlock(cacheBlock)
	);

endmodule

`default_nettype wire

/* tests/memoryModel.sv */
// Backing memory model
`default_nettype none

module memoryModel (
	input wire logic clock,
	input wire logic reset,
	input wire logic memRen,
	input wire logic memWen,
	input wire logic [dcachePkg::addrWidth-dcachePkg::offsetWidth-1:0] memBlockAddr,
	input wire dcachePkg::dcacheBlock memDin,
	output logic memReadReady,
	output logic memWriteDone,
	output dcachePkg::dcacheBlock memDout
);
	timeunit 1ns;
	timeprecision 100ps;

	import dcachePkg::*;

	dcacheBlock blocks [256];
	int writeCount;
	int seed = 22435;
	logic busy;
	int unsigned delay;

	always @(posedge clock or negedge reset) begin
		if (!reset) begin
			// each byte holds the low bits of three times its address
			for (int b = 0; b < 256; b++) begin
				for (int i = 0; i < blockBytes; i++) begin
					blocks[b].bytes[i] <= 8'((b * blockBytes + i) * 3);
				end
			end
			writeCount <= 0;
			busy <= 1'b0;
			delay <= 0;
			memReadReady <= 1'b0;
			memWriteDone <= 1'b0;
			memDout <= '0;
		end else if (memReadReady || memWriteDone) begin
			// one cycle pulse, then idle for a cycle
			memReadReady <= 1'b0;
			memWriteDone <= 1'b0;
			busy <= 1'b0;
		end else if (!busy) begin
			if (memRen || memWen) begin
				busy <= 1'b1;
				delay <= $unsigned($random(seed)) % 7;
			end
		end else if (delay != 0) begin
			delay <= delay - 1;
		end else if (memRen) begin
			memDout <= blocks[memBlockAddr[7:0]];
			memReadReady <= 1'b1;
		end else if (memWen) begin
			blocks[memBlockAddr[7:0]] <= memDin;
			writeCount <= writeCount + 1;
			memWriteDone <= 1'b1;
		end else begin
			busy <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* tests/dcacheController_chk.sv */
// Controller protocol checks
`default_nettype none

module dcacheControllerChk (
	input wire logic clock,
	input wire logic reset,
	input wire dcachePkg::controllerState state,
	input wire logic ren,
	input wire logic wen,
	input wire logic hit,
	input wire logic stall,
	input wire logic memRen,
	input wire logic memWen
);
	timeunit 1ns;
	timeprecision 100ps;

	import dcachePkg::*;

	noDualAccess: assert property (@(posedge clock) disable iff (!reset)
		!(memRen && memWen))
		else $error("memRen and memWen are high together");

	// hit or no request in idle never stalls
	idleNoStall: assert property (@(posedge clock) disable iff (!reset)
		(state == idle && (hit || !(ren ^ wen))) |-> !stall)
		else $error("stall raised in idle without a miss");

	writeOnlyInWriteBack: assert property (@(posedge clock) disable iff (!reset)
		memWen |-> state == writeBack)
		else $error("memWen high outside writeBack");

endmodule

bind dcacheController dcacheControllerChk controllerChk (
	.clock(clock),
	.reset(reset),
	.state(state),
	.ren(ren),
	.wen(wen),
	.hit(hit),
	.stall(stall),
	.memRen(memRen),
	.memWen(memWen)
);

`default_nettype wire

/* tests/dcacheTb.sv */
// Data cache testbench
`default_nettype none

module dcacheTb;
	timeunit 1ns;
	timeprecision 100ps;

	import dcachePkg::*;

	localparam int numSets = 16;
	localparam int requestTimeout = 200;
	localparam int shadowBytes = 4096;

	logic clock;
	logic reset;
	logic ren;
	logic wen;
	logic [addrWidth-1:0] addr;
	logic [wordBytes-1:0] byteSelect;
	logic [wordBits-1:0] din;
	logic stall;
	logic [wordBits-1:0] dout;
	logic memRen;
	logic memWen;
	logic [addrWidth-offsetWidth-1:0] memBlockAddr;
	dcacheBlock memDin;
	dcacheBlock memDout;
	logic memReadReady;
	logic memWriteDone;

	// expected memory contents, byte addressed
	logic [7:0] shadow [shadowBytes];
	int seed = 22435;

	dcacheTop #(.numSets(numSets)) DUT (.*);
	memoryModel mem (.*);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	task automatic compareValue(input string name, input logic [blockBits-1:0] expected,
			input logic [blockBits-1:0] actual);
		if (expected !== actual) begin
			$display("[ERROR] %0t %s expected %0h actual %0h", $time, name, expected, actual);
			$display("Test failures found");
			$fatal(1);
		end
	endtask

	function automatic logic [wordBits-1:0] shadowWord(input logic [addrWidth-1:0] address);
		int base;
		base = int'(address[11:2]) * wordBytes;
		return {shadow[base + 3], shadow[base + 2], shadow[base + 1], shadow[base]};
	endfunction

	function automatic dcacheBlock shadowBlock(input int blockNum);
		dcacheBlock result;
		for (int i = 0; i < blockBytes; i++) begin
			result.bytes[i] = shadow[blockNum * blockBytes + i];
		end
		return result;
	endfunction

	// one request, held until stall is low
	task automatic issueRequest(input logic isRead, input logic [addrWidth-1:0] address,
			input logic [wordBytes-1:0] select, input logic [wordBits-1:0] data,
			output logic [wordBits-1:0] readData, output int stallCycles);
		int base;
		base = int'(address[11:2]) * wordBytes;
		@(posedge clock);
		ren <= isRead;
		wen <= !isRead;
		addr <= address;
		byteSelect <= select;
		din <= data;
		stallCycles = 0;
		@(negedge clock);
		while (stall) begin
			if (stallCycles == requestTimeout) begin
				$display("request to address %h timed out with stall still high", address);
				$display("Test failures found");
				$fatal(1);
			end
			stallCycles++;
			@(negedge clock);
		end
		readData = dout;
		@(posedge clock);
		ren <= 1'b0;
		wen <= 1'b0;
		// write lands at this edge
		if (!isRead) begin
			for (int j = 0; j < wordBytes; j++) begin
				if (select[j]) begin
					shadow[base + j] = data[j * 8 +: 8];
				end
			end
		end
	endtask

	task automatic checkResetState();
		@(negedge clock);
		compareValue("stall", 1'b0, stall);
		compareValue("memRen", 1'b0, memRen);
		compareValue("memWen", 1'b0, memWen);
		// ren and wen together is no request
		@(posedge clock);
		ren <= 1'b1;
		wen <= 1'b1;
		addr <= 32'h0000_0080;
		byteSelect <= 4'hf;
		din <= 32'h1234_5678;
		repeat (4) begin
			@(negedge clock);
			compareValue("stall", 1'b0, stall);
			compareValue("memRen", 1'b0, memRen);
			compareValue("memWen", 1'b0, memWen);
		end
		@(posedge clock);
		ren <= 1'b0;
		wen <= 1'b0;
	endtask

	task automatic readMissThenHit();
		logic [wordBits-1:0] data;
		int cycles;
		issueRequest(1'b1, 32'h40, 4'hf, '0, data, cycles);
		compareValue("missStalled", 1'b1, cycles != 0);
		compareValue("dout", shadowWord(32'h40), data);
		issueRequest(1'b1, 32'h48, 4'hf, '0, data, cycles);
		compareValue("hitStallCycles", 0, cycles);
		compareValue("dout", shadowWord(32'h48), data);
	endtask

	task automatic partialWriteHit();
		logic [wordBits-1:0] data;
		int cycles;
		issueRequest(1'b0, 32'h44, 4'b0101, 32'haabb_ccdd, data, cycles);
		compareValue("writeStallCycles", 0, cycles);
		issueRequest(1'b1, 32'h44, 4'hf, '0, data, cycles);
		compareValue("dout", shadowWord(32'h44), data);
		issueRequest(1'b1, 32'h40, 4'hf, '0, data, cycles);
		compareValue("dout", shadowWord(32'h40), data);
	endtask

	task automatic dirtyEviction();
		logic [wordBits-1:0] data;
		int cycles;
		int writesBefore;
		dcacheBlock victim;
		writesBefore = mem.writeCount;
		victim = shadowBlock(4);
		// block 20 shares set 4 with the dirty block 4
		issueRequest(1'b1, 32'h144, 4'hf, '0, data, cycles);
		compareValue("memWriteCount", writesBefore + 1, mem.writeCount);
		compareValue("memBlock4", victim, mem.blocks[4]);
		compareValue("dout", shadowWord(32'h144), data);
	endtask

	task automatic randomTraffic();
		logic [addrWidth-1:0] address;
		logic isRead;
		logic [wordBytes-1:0] select;
		logic [wordBits-1:0] data;
		logic [wordBits-1:0] readData;
		int cycles;
		repeat (200) begin
			address = ($unsigned($random(seed)) % 64) * blockBytes
				+ ($unsigned($random(seed)) % blockWords) * wordBytes;
			isRead = 1'($random(seed));
			select = 4'($random(seed));
			data = $random(seed);
			issueRequest(isRead, address, select, data, readData, cycles);
			if (isRead) begin
				compareValue("dout", shadowWord(address), readData);
			end
		end
	endtask

	initial begin
		reset = 1'b0;
		ren = 1'b0;
		wen = 1'b0;
		addr = '0;
		byteSelect = '0;
		din = '0;
		for (int i = 0; i < shadowBytes; i++) begin
			shadow[i] = 8'(i * 3);
		end
		repeat (8) @(posedge clock);
		reset <= 1'b1;
		checkResetState();
		readMissThenHit();
		partialWriteHit();
		dirtyEviction();
		randomTraffic();
		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire

/* build.f */
source/dcachePkg.sv
source/dcacheController.sv
source/dcacheTagStore.sv
source/dcacheDataStore.sv
source/dcacheTop.sv
tests/memoryModel.sv
tests/dcacheController_chk.sv
tests/dcacheTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the data cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
	--top-module dcacheTb -f build.f -o dcacheSim
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
	echo "Verilator build failed with status $buildStatus"
	exit 1
fi

simOutput=$(./obj_dir/dcacheSim 2>&1)
simStatus=$?
echo "$simOutput"
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if echo "$simOutput" | grep -qF 'All tests passed!'; then
	exit 0
else
	echo "Pass message not found in simulation output"
	exit 1
fi
